// File: sim.f
logic/ram_exp_pkg.sv
logic/bus_cycle_sampler.sv
logic/bank_select_reg.sv
logic/block_mapper.sv
logic/cpc_ram_expansion.sv
tests/ram_expansion_chk.sv
tests/tb_cpc_ram_expansion.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the RAM expansion testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
top=tb_cpc_ram_expansion

verilator --binary --timing --assert -f sim.f --top-module "$top" -Mdir "$build_dir"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -qx "all tests passed" "$log_file"; then
  exit 0
else
  echo "Pass message not found in $log_file"
  exit 1
fi

// File: tests/tb_cpc_ram_expansion.sv
`timescale 1ns/10ps
`default_nettype none

// Table driven testbench for the RAM expansion control logic
// Each entry loads the bank register by an I/O write, then runs one memory access
module tb_cpc_ram_expansion import ram_exp_pkg::*; ();

  localparam logic [BANK_W-1:0] SHADOW_BANK_SEL = 3'd3;
  localparam int RESET_CYCLES = 8;
  localparam int CYCLES_PER_ENTRY = 40;

  // Kinds of memory access an entry can run
  localparam logic [1:0] ACC_RD = 2'd0;
  localparam logic [1:0] ACC_WR = 2'd1;
  localparam logic [1:0] ACC_RFSH = 2'd2;

  // Stimulus fields come first and the expected outputs follow them
  typedef struct packed {
    logic                ovd;
    logic                shd;
    logic                io_a15;
    logic [7:0]          cmd;
    logic [PAGE_W-1:0]   page;
    logic [1:0]          acc;
    logic                cs_b;
    logic                dis;
    logic [RAMADR_W-1:0] adr;
    logic                rd_drv;
    logic                a15_drv;
  } entry_t;

  logic clk = 1'b0;
  logic reset_b, mreq_b, iorq_b, wr_b, rd_b, m1_b, rfsh_b, adr15, adr14;
  logic [7:0] data;
  logic overdrive_mode, shadow_mode;
  logic ramcs_b, ramdis, rd_drive, adr15_drive;
  logic [RAMADR_W-1:0] ramadrhi;

  entry_t stim_q[$];
  int fails = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  // Reference copy of the bank register, advanced while the table is built
  logic [BANK_W-1:0]   m_bank;
  logic [SCHEME_W-1:0] m_scheme;

  cpc_ram_expansion #(
    .SHADOW_BANK (SHADOW_BANK_SEL)
  ) u_cpc_ram_expansion (
    .clk            (clk),
    .reset_b        (reset_b),
    .mreq_b         (mreq_b),
    .iorq_b         (iorq_b),
    .wr_b           (wr_b),
    .rd_b           (rd_b),
    .m1_b           (m1_b),
    .rfsh_b         (rfsh_b),
    .adr15          (adr15),
    .adr14          (adr14),
    .data           (data),
    .overdrive_mode (overdrive_mode),
    .shadow_mode    (shadow_mode),
    .ramcs_b        (ramcs_b),
    .ramdis         (ramdis),
    .ramadrhi       (ramadrhi),
    .rd_drive       (rd_drive),
    .adr15_drive    (adr15_drive)
  );

  always #50 clk = ~clk;

  // Upper bound on the run length that is set once the table is known
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
      $display("tests failed");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected outputs of one access follow from the mapping table and the strobe rules
  function automatic entry_t predict(input entry_t e);
    entry_t r;
    logic is_c3, is_wr, is_rfsh, in_exp, sel;
    logic [SCHEME_W-1:0] offs;
    logic [PAGE_W-1:0] blk;
    r = e;
    is_c3 = (m_scheme == SCHEME_C3);
    is_wr = (e.acc == ACC_WR);
    is_rfsh = (e.acc == ACC_RFSH);
    in_exp = 1'b0;
    blk = PAGE_TOP;
    offs = m_scheme - SCHEME_WIN_BASE;
    case (m_scheme)
      SCHEME_TOP, SCHEME_C3: begin
        in_exp = (e.page == PAGE_TOP);
      end
      SCHEME_ALL: begin
        in_exp = 1'b1;
        blk = e.page;
      end
      default: begin
        // Schemes 4 to 7 open block 0 to 3 at the window and scheme 0 maps nothing
        if (m_scheme >= SCHEME_WIN_BASE) begin
          in_exp = (e.page == PAGE_WIN);
          blk = offs[PAGE_W-1:0];
        end
      end
    endcase
    if (in_exp) begin
      sel = 1'b1;
      r.adr = {m_bank, blk};
    end else if (e.shd && is_c3 && (e.page == PAGE_WIN)) begin
      sel = 1'b1;
      r.adr = {SHADOW_BANK_SEL, PAGE_TOP};
    end else if (e.shd) begin
      // The shadow copy is only written and reads stay on the internal RAM
      sel = is_wr;
      r.adr = {SHADOW_BANK_SEL, e.page};
    end else begin
      sel = 1'b0;
      r.adr = '0;
    end
    r.dis = sel;
    r.cs_b = !(sel && !is_rfsh);
    r.rd_drv = e.ovd && in_exp && is_wr;
    // The captured A14 qualifies the A15 overdrive
    r.a15_drv = e.ovd && is_c3 && e.page[0] && (is_wr || !e.shd);
    return r;
  endfunction

  task automatic add_entry(input logic ovd, input logic shd, input logic io_a15,
                           input logic [7:0] cmd, input logic [PAGE_W-1:0] page,
                           input logic [1:0] acc);
    entry_t e;
    e = '0;
    e.ovd = ovd;
    e.shd = shd;
    e.io_a15 = io_a15;
    e.cmd = cmd;
    e.page = page;
    e.acc = acc;
    // Only a write with A15 low and the command prefix loads the register
    if (!io_a15 && (cmd[7:6] == CMD_PREFIX)) begin
      m_bank = cmd[5:3];
      if (shd && (m_bank == SHADOW_BANK_SEL)) begin
        m_bank[0] = 1'b0;
      end
      m_scheme = cmd[2:0];
    end
    stim_q.push_back(predict(e));
  endtask

  task automatic build_table();
    int b, s, p;
    logic [31:0] rnd;
    logic [7:0] cmd;
    logic [1:0] acc;
    m_bank = '0;
    m_scheme = '0;
    // The reset state stays because the command byte carries no prefix
    for (p = 0; p < 4; p++) begin
      add_entry(1'b0, 1'b0, 1'b0, 8'h00, 2'(p), ACC_RD);
      add_entry(1'b0, 1'b0, 1'b0, 8'h00, 2'(p), ACC_WR);
    end
    for (b = 0; b < 8; b++) begin
      for (s = 0; s < 8; s++) begin
        for (p = 0; p < 4; p++) begin
          acc = ((b + p) % 2 == 0) ? ACC_RD : ACC_WR;
          add_entry(1'b0, 1'b0, 1'b0, {CMD_PREFIX, 3'(b), 3'(s)}, 2'(p), acc);
        end
      end
    end
    // Bank 5 with all pages mapped is followed by writes that must be ignored
    add_entry(1'b0, 1'b0, 1'b0, 8'hEA, 2'd1, ACC_RD);
    add_entry(1'b0, 1'b0, 1'b1, 8'hC1, 2'd1, ACC_RD);
    add_entry(1'b0, 1'b0, 1'b0, 8'h81, 2'd2, ACC_WR);
    add_entry(1'b0, 1'b0, 1'b0, 8'h47, 2'd3, ACC_RD);
    // Overdrive with bank 2 on the top page
    add_entry(1'b1, 1'b0, 1'b0, 8'hD1, 2'd3, ACC_WR);
    add_entry(1'b1, 1'b0, 1'b0, 8'hD1, 2'd3, ACC_RD);
    add_entry(1'b1, 1'b0, 1'b0, 8'hD1, 2'd0, ACC_WR);
    add_entry(1'b1, 1'b0, 1'b0, 8'hD1, 2'd3, ACC_RFSH);
    for (p = 0; p < 4; p++) begin
      add_entry(1'b0, 1'b1, 1'b0, 8'hC8, 2'(p), ACC_WR);
      add_entry(1'b0, 1'b1, 1'b0, 8'hC8, 2'(p), ACC_RD);
    end
    add_entry(1'b0, 1'b1, 1'b0, {CMD_PREFIX, SHADOW_BANK_SEL, SCHEME_ALL}, 2'd2, ACC_RD);
    // C3 remap of page 1 with and without the shadow copy
    cmd = {CMD_PREFIX, 3'd4, SCHEME_C3};
    add_entry(1'b1, 1'b0, 1'b0, cmd, 2'd1, ACC_RD);
    add_entry(1'b1, 1'b0, 1'b0, cmd, 2'd1, ACC_WR);
    add_entry(1'b1, 1'b1, 1'b0, cmd, 2'd1, ACC_WR);
    add_entry(1'b1, 1'b1, 1'b0, cmd, 2'd1, ACC_RD);
    add_entry(1'b1, 1'b1, 1'b0, cmd, 2'd1, ACC_RFSH);
    rnd = 32'd78;
    for (b = 0; b < 40; b++) begin
      rnd = xorshift(rnd);
      cmd = rnd[16] ? {CMD_PREFIX, rnd[5:0]} : rnd[7:0];
      acc = (rnd[14:13] == 2'd3) ? ACC_WR : rnd[14:13];
      add_entry(rnd[20], rnd[21], rnd[9] & rnd[10], cmd, rnd[12:11], acc);
    end
  endtask

  task automatic report_mismatch(input int idx, input string what,
                                 input logic [7:0] got, input logic [7:0] exp);
    fails++;
    $display("ERR %0t: entry %0d %s is %0h, expected %0h", $time, idx, what, got, exp);
    $display("tests failed");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic check_outputs(input int idx, input entry_t e);
    assert (ramcs_b === e.cs_b)
      else report_mismatch(idx, "ramcs_b", 8'(ramcs_b), 8'(e.cs_b));
    assert (ramdis === e.dis)
      else report_mismatch(idx, "ramdis", 8'(ramdis), 8'(e.dis));
    assert (ramadrhi === e.adr)
      else report_mismatch(idx, "ramadrhi", 8'(ramadrhi), 8'(e.adr));
    assert (rd_drive === e.rd_drv)
      else report_mismatch(idx, "rd_drive", 8'(rd_drive), 8'(e.rd_drv));
    assert (adr15_drive === e.a15_drv)
      else report_mismatch(idx, "adr15_drive", 8'(adr15_drive), 8'(e.a15_drv));
  endtask

  task automatic run_entry(input int idx, input entry_t e);
    @(posedge clk);
    overdrive_mode <= e.ovd;
    shadow_mode <= e.shd;
    @(posedge clk);
    iorq_b <= 1'b0;
    wr_b <= 1'b0;
    adr15 <= e.io_a15;
    data <= e.cmd;
    @(posedge clk);
    iorq_b <= 1'b1;
    wr_b <= 1'b1;
    repeat (2) @(posedge clk);
    mreq_b <= 1'b0;
    adr15 <= e.page[1];
    adr14 <= e.page[0];
    rd_b <= (e.acc != ACC_RD);
    wr_b <= (e.acc != ACC_WR);
    rfsh_b <= (e.acc != ACC_RFSH);
    repeat (2) @(posedge clk);
    // The open driver on the board pulls A15 high while adr15_drive is set
    if (e.a15_drv) begin
      adr15 <= 1'b1;
    end
    // Sample in the middle of the access three clocks after mreq_b falls
    @(posedge clk);
    @(negedge clk);
    check_outputs(idx, e);
    @(posedge clk);
    mreq_b <= 1'b1;
    rd_b <= 1'b1;
    wr_b <= 1'b1;
    rfsh_b <= 1'b1;
    @(posedge clk);
  endtask

  initial begin
    build_table();
    cycle_limit = CYCLES_PER_ENTRY * stim_q.size() + RESET_CYCLES;
    reset_b <= 1'b0;
    mreq_b <= 1'b1;
    iorq_b <= 1'b1;
    wr_b <= 1'b1;
    rd_b <= 1'b1;
    m1_b <= 1'b1;
    rfsh_b <= 1'b1;
    adr15 <= 1'b0;
    adr14 <= 1'b0;
    data <= 8'h00;
    overdrive_mode <= 1'b0;
    shadow_mode <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_b <= 1'b1;
    foreach (stim_q[i]) begin
      run_entry(i, stim_q[i]);
    end
    if (fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/ram_expansion_chk.sv
`timescale 1ns/10ps
`default_nettype none

// Strobe rules of the RAM expansion, sampled on every rising clock edge
module ram_expansion_chk (
  input logic clk,
  input logic reset_b,
  input logic mreq_b,
  input logic overdrive_mode,
  input logic ramcs_b,
  input logic rd_drive,
  input logic adr15_drive
);

  // The SRAM may only be selected inside a memory cycle
  cs_in_cycle: assert property (@(posedge clk) disable iff (!reset_b) mreq_b |-> ramcs_b)
    else $error("ramcs_b is low while mreq_b is high");

  // RD is only overdriven on boards that use the overdrive option
  rd_needs_overdrive: assert property (@(posedge clk) disable iff (!reset_b)
    rd_drive |-> overdrive_mode)
    else $error("rd_drive is set without overdrive_mode");

  // Same for A15
  a15_needs_overdrive: assert property (@(posedge clk) disable iff (!reset_b)
    adr15_drive |-> overdrive_mode)
    else $error("adr15_drive is set without overdrive_mode");

endmodule

// Attach the checker to every instance of the top level
bind cpc_ram_expansion ram_expansion_chk u_chk (
  .clk            (clk),
  .reset_b        (reset_b),
  .mreq_b         (mreq_b),
  .overdrive_mode (overdrive_mode),
  .ramcs_b        (ramcs_b),
  .rd_drive       (rd_drive),
  .adr15_drive    (adr15_drive)
);

`default_nettype wire

// File: logic/cpc_ram_expansion.sv
`timescale 1ns/10ps
`default_nettype none

// Control logic of the 512K RAM expansion
// The bus sampler tracks the CPU memory cycle, the bank register holds the scheme
// written by the CPU, and the mapper turns both into SRAM and overdrive controls
module cpc_ram_expansion import ram_exp_pkg::*; #(
  // Bank reserved for the shadow copy of the internal RAM
  parameter logic [BANK_W-1:0] SHADOW_BANK = 3'd3
) (
  input  logic                clk,
  input  logic                reset_b,

  // Z80 bus strobes, all active low
  input  logic                mreq_b,
  input  logic                iorq_b,
  input  logic                wr_b,
  input  logic                rd_b,
  input  logic                m1_b,
  input  logic                rfsh_b,

  // Top two address bits and the data bus
  input  logic                adr15,
  input  logic                adr14,
  input  logic [7:0]          data,

  // DIP switch options
  input  logic                overdrive_mode,
  input  logic                shadow_mode,

  // SRAM and internal RAM controls
  output logic                ramcs_b,
  output logic                ramdis,
  output logic [RAMADR_W-1:0] ramadrhi,

  // Drive enables for the open drivers on RD and A15
  output logic                rd_drive,
  output logic                adr15_drive
);

  // Memory write cycle flag and page index captured at cycle start
  logic              mwr_cyc;
  logic [PAGE_W-1:0] page_q;

  // Contents of the bank register
  logic [BANK_W-1:0]   bank_q;
  logic [SCHEME_W-1:0] scheme_q;
  logic                mode_c3_q;

  bus_cycle_sampler u_sampler (
    .clk     (clk),
    .reset_b (reset_b),
    .mreq_b  (mreq_b),
    .rd_b    (rd_b),
    .m1_b    (m1_b),
    .rfsh_b  (rfsh_b),
    .adr15   (adr15),
    .adr14   (adr14),
    .mwr_cyc (mwr_cyc),
    .page_q  (page_q)
  );

  bank_select_reg #(
    .SHADOW_BANK (SHADOW_BANK)
  ) u_bank (
    .clk         (clk),
    .reset_b     (reset_b),
    .iorq_b      (iorq_b),
    .wr_b        (wr_b),
    .adr15       (adr15),
    .shadow_mode (shadow_mode),
    .data        (data),
    .bank_q      (bank_q),
    .scheme_q    (scheme_q),
    .mode_c3_q   (mode_c3_q)
  );

  block_mapper #(
    .SHADOW_BANK (SHADOW_BANK)
  ) u_mapper (
    .mreq_b         (mreq_b),
    .rfsh_b         (rfsh_b),
    .adr15          (adr15),
    .adr14          (adr14),
    .overdrive_mode (overdrive_mode),
    .shadow_mode    (shadow_mode),
    .mwr_cyc        (mwr_cyc),
    .page_q         (page_q),
    .bank_q         (bank_q),
    .scheme_q       (scheme_q),
    .mode_c3_q      (mode_c3_q),
    .ramcs_b        (ramcs_b),
    .ramdis         (ramdis),
    .rd_drive       (rd_drive),
    .adr15_drive    (adr15_drive),
    .ramadrhi       (ramadrhi)
  );

endmodule

`default_nettype wire

// File: logic/block_mapper.sv
`timescale 1ns/10ps
`default_nettype none

// Maps each CPU memory access onto the expansion SRAM or the internal RAM
// The mapping is purely combinational from the bus and the registered state
module block_mapper import ram_exp_pkg::*; #(
  // Bank reserved for the shadow copy of the internal RAM
  parameter logic [BANK_W-1:0] SHADOW_BANK = 3'd3
) (
  input  logic                mreq_b,
  input  logic                rfsh_b,
  input  logic                adr15,
  input  logic                adr14,
  input  logic                overdrive_mode,
  input  logic                shadow_mode,
  input  logic                mwr_cyc,
  input  logic [PAGE_W-1:0]   page_q,
  input  logic [BANK_W-1:0]   bank_q,
  input  logic [SCHEME_W-1:0] scheme_q,
  input  logic                mode_c3_q,
  output logic                ramcs_b,
  output logic                ramdis,
  output logic                rd_drive,
  output logic                adr15_drive,
  output logic [RAMADR_W-1:0] ramadrhi
);

  // Page index used for the decode
  logic [PAGE_W-1:0] page;

  // Expansion hit and the block of the bank it uses
  logic              hit;
  logic [PAGE_W-1:0] block;

  // Block opened in the page 1 window by schemes 4 to 7
  logic [SCHEME_W-1:0] win_offset;

  // Access served from the expansion RAM proper rather than the shadow bank
  logic exp_ram;

  // Internal SRAM select before qualification with the bus strobes
  logic sel;

  // In scheme C3 the CPU address is remapped while A15 is being overdriven,
  // so the top bit is taken from the value captured at the start of the cycle
  always_comb begin
    if (mode_c3_q) begin
      page = {page_q[PAGE_W-1], adr14};
    end else begin
      page = {adr15, adr14};
    end
  end

  assign win_offset = scheme_q - SCHEME_WIN_BASE;

  // Decide whether the scheme places this page in the expansion bank
  always_comb begin
    hit   = 1'b0;
    block = '0;
    if (scheme_q == SCHEME_TOP) begin
      hit   = (page == PAGE_TOP);
      block = PAGE_TOP;
    end else if (scheme_q == SCHEME_ALL) begin
      // Every page maps straight onto the block of the same number
      hit   = 1'b1;
      block = page;
    end else if (scheme_q == SCHEME_C3) begin
      hit   = (page == PAGE_TOP);
      block = PAGE_TOP;
    end else if (scheme_q >= SCHEME_WIN_BASE) begin
      hit   = (page == PAGE_WIN);
      block = win_offset[PAGE_W-1:0];
    end
    // Scheme 0 leaves every page on the internal RAM
  end

  // Form the SRAM address and select for hits, shadow accesses and misses
  always_comb begin
    exp_ram  = 1'b0;
    sel      = 1'b0;
    ramadrhi = '0;
    if (hit) begin
      exp_ram  = 1'b1;
      sel      = 1'b1;
      ramadrhi = {bank_q, block};
    end else if (shadow_mode && mode_c3_q && (page == PAGE_WIN)) begin
      // C3 shows internal block 3 in the window, and with A15 overdriven
      // for writes only the reads have to come from the shadow copy
      sel      = 1'b1;
      ramadrhi = {SHADOW_BANK, PAGE_TOP};
    end else if (shadow_mode) begin
      // Every write to internal RAM is mirrored into the shadow bank
      // so that a later C3 read finds an up to date copy
      sel      = mwr_cyc;
      ramadrhi = {SHADOW_BANK, page};
    end
  end

  // Internal RAM is disabled whenever the SRAM takes the access
  assign ramdis = sel;

  // Refresh cycles also pull mreq_b low and must never reach the SRAM
  assign ramcs_b = !(sel && !mreq_b && rfsh_b);

  // A 464 without the RAMDIS line is forced to treat an expansion write as a
  // read so the internal RAM is left untouched
  assign rd_drive = overdrive_mode && exp_ram && mwr_cyc;

  // A15 is pulled high for C3 accesses to page 1 so the internal RAM sees block 3
  // Without shadow RAM reads need it too, with shadow RAM only writes do
  always_comb begin
    if (shadow_mode) begin
      adr15_drive = overdrive_mode && mode_c3_q && page_q[0] && mwr_cyc;
    end else begin
      adr15_drive = overdrive_mode && mode_c3_q && page_q[0] && !mreq_b;
    end
  end

endmodule

`default_nettype wire

// File: logic/bank_select_reg.sv
`timescale 1ns/10ps
`default_nettype none

// Bank register loaded by the CPU with an I/O write to an address with A15 low
// The command byte is 11 bbb sss with bank bbb and block scheme sss
module bank_select_reg import ram_exp_pkg::*; #(
  // Bank kept for the shadow copy of the internal RAM
  parameter logic [BANK_W-1:0] SHADOW_BANK = 3'd3
) (
  input  logic                clk,
  input  logic                reset_b,
  input  logic                iorq_b,
  input  logic                wr_b,
  input  logic                adr15,
  input  logic                shadow_mode,
  input  logic [7:0]          data,
  output logic [BANK_W-1:0]   bank_q,
  output logic [SCHEME_W-1:0] scheme_q,
  output logic                mode_c3_q
);

  // Fields of the command byte
  logic [1:0]          cmd_prefix;
  logic [BANK_W-1:0]   cmd_bank;
  logic [SCHEME_W-1:0] cmd_scheme;

  // Valid bank select write on the bus this cycle
  logic sel_wr;

  // Bank value after the shadow alias has been applied
  logic [BANK_W-1:0] bank_next;

  assign cmd_prefix = data[7:6];
  assign cmd_bank   = data[SCHEME_W +: BANK_W];
  assign cmd_scheme = data[SCHEME_W-1:0];

  // Only the gate array port range has A15 low, and the prefix separates the
  // RAM command from the other gate array functions
  assign sel_wr = !iorq_b && !wr_b && !adr15 && (cmd_prefix == CMD_PREFIX);

  // With shadow RAM in use the shadow bank is never given out as ordinary
  // expansion memory and its requests land on the neighbouring even bank
  always_comb begin
    bank_next = cmd_bank;
    if (shadow_mode && (cmd_bank == SHADOW_BANK)) begin
      bank_next = {cmd_bank[BANK_W-1:1], 1'b0};
    end
  end

  // The write may be held for several clocks and simply reloads the same value
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      bank_q    <= '0;
      scheme_q  <= '0;
      mode_c3_q <= 1'b0;
    end else if (sel_wr) begin
      bank_q    <= bank_next;
      scheme_q  <= cmd_scheme;
      // Decoded here so the mapper and the A15 overdrive see a single flag
      mode_c3_q <= (cmd_scheme == SCHEME_C3);
    end
  end

endmodule

`default_nettype wire

// File: logic/bus_cycle_sampler.sv
`timescale 1ns/10ps
`default_nettype none

// Follows the Z80 memory cycle on the system clock
// It flags memory write cycles and remembers the page the cycle started on
module bus_cycle_sampler import ram_exp_pkg::*; (
  input  logic              clk,
  input  logic              reset_b,
  input  logic              mreq_b,
  input  logic              rd_b,
  input  logic              m1_b,
  input  logic              rfsh_b,
  input  logic              adr15,
  input  logic              adr14,
  output logic              mwr_cyc,
  output logic [PAGE_W-1:0] page_q
);

  // Previous sample of mreq_b, which idles high
  logic mreq_b_q;

  // First clock edge that sees mreq_b low
  logic mreq_fall;

  // Start of a memory cycle that is neither a refresh, an opcode fetch nor a read
  logic mwr_start;

  assign mreq_fall = !mreq_b && mreq_b_q;

  // The Z80 asserts wr_b late in the write cycle, so a write is recognised
  // by the absence of rd_b at the start of the cycle
  assign mwr_start = mreq_fall && rfsh_b && rd_b && m1_b;

  always_ff @(posedge clk) begin
    if (!reset_b) begin
      mreq_b_q <= 1'b1;
    end else begin
      mreq_b_q <= mreq_b;
    end
  end

  // The write flag is set from the cycle start and holds until mreq_b goes back high
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      mwr_cyc <= 1'b0;
    end else if (mwr_start) begin
      mwr_cyc <= 1'b1;
    end else if (mreq_b) begin
      mwr_cyc <= 1'b0;
    end
  end

  // Capture the page index once per memory cycle
  // In the C3 scheme A15 is overdriven later in the cycle, so the live A15 cannot
  // be trusted after the start and the captured copy keeps the mapping stable
  always_ff @(posedge clk) begin
    if (!reset_b) begin
      page_q <= '0;
    end else if (mreq_fall) begin
      page_q <= {adr15, adr14};
    end
  end

endmodule

`default_nettype wire

// File: logic/ram_exp_pkg.sv
`default_nettype none

package ram_exp_pkg;

  // Width of the 64K bank number held in the bank register
  localparam int BANK_W = 3;

  // Width of the block scheme field that follows the bank in the command byte
  localparam int SCHEME_W = 3;

  // A 16K page is picked by CPU address bits 15 and 14
  localparam int PAGE_W = 2;

  // The SRAM high address is the bank followed by the 16K block
  localparam int RAMADR_W = BANK_W + PAGE_W;

  // Data bits 7:6 must both be set for an I/O write to load the bank register
  localparam logic [1:0] CMD_PREFIX = 2'b11;

  // Scheme 3 maps page 3 and remaps page 1 onto block 3 of the internal or shadow RAM
  localparam logic [SCHEME_W-1:0] SCHEME_C3 = 3'd3;

  // Scheme 2 replaces all four pages by the four blocks of the selected bank
  localparam logic [SCHEME_W-1:0] SCHEME_ALL = 3'd2;

  // Scheme 1 replaces only the top page
  localparam logic [SCHEME_W-1:0] SCHEME_TOP = 3'd1;

  // Schemes 4 to 7 open one block of the bank in the page 1 window
  localparam logic [SCHEME_W-1:0] SCHEME_WIN_BASE = 3'd4;

  // Page index of the 0x4000 window
  localparam logic [PAGE_W-1:0] PAGE_WIN = 2'd1;

  // Page index of the 0xC000 page, which is also the number of the top block
  localparam logic [PAGE_W-1:0] PAGE_TOP = 2'd3;

endpackage

`default_nettype wire
